/* fpuPkg.sv */
package fpuPkg;

	// Command opcodes.
	typedef enum logic [1:0]
	{
		opLoad = 2'd0,
		opMul  = 2'd1,
		opConv = 2'd2
	} fpuOpE;

	localparam int regAddrW = 4;
	localparam int numRegs  = 16;
	localparam int dataW    = 64;		// Binary64 word.
	localparam int expBias  = 1023;

	// Cycles from operand capture to a valid result.
	localparam int mulLatency  = 4;
	localparam int convLatency = 2;

	localparam int queueDepth = 2;		// Per low-priority producer.
	localparam int queueCntW  = $clog2(queueDepth + 1);
	localparam int queueIdxW  = $clog2(queueDepth);

endpackage

/* fpuRegFile.sv */
`timescale 1ns/1ps

module fpuRegFile import fpuPkg::*;
(
	input  logic                clock,
	input  logic                arstN,
	input  logic [regAddrW-1:0] rdAddrA,
	input  logic [regAddrW-1:0] rdAddrB,
	input  logic [regAddrW-1:0] rdAddrC,
	output logic [dataW-1:0]    rdDataA,
	output logic [dataW-1:0]    rdDataB,
	output logic [dataW-1:0]    rdDataC,
	input  logic                wrEn,
	input  logic [regAddrW-1:0] wrAddr,
	input  logic [dataW-1:0]    wrData
);

	logic [dataW-1:0] regs [numRegs];

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			for (int i = 0; i < numRegs; i++)
				regs[i] <= '0;
		end
		else if (wrEn)
		begin
			regs[wrAddr] <= wrData;
		end
	end

	// Reads see the value before a same-cycle write.
	assign rdDataA = regs[rdAddrA];
	assign rdDataB = regs[rdAddrB];
	assign rdDataC = regs[rdAddrC];

endmodule

/* fpuMul.sv */
`timescale 1ns/1ps

module fpuMul import fpuPkg::*;
(
	input  logic                clock,
	input  logic                arstN,
	input  logic                inValid,
	input  logic [regAddrW-1:0] inTag,
	input  logic [dataW-1:0]    inA,
	input  logic [dataW-1:0]    inB,
	output logic                outValid,
	output logic [regAddrW-1:0] outTag,
	output logic [dataW-1:0]    outData
);

	logic                sgnA;
	logic                sgnB;
	logic [10:0]         expA;
	logic [10:0]         expB;
	logic [53:0]         sigA;
	logic [53:0]         sigB;

	logic                sgnS1;
	logic [12:0]         expS1;
	logic                zeroS1;
	logic [35:0]         pp01S1;
	logic [35:0]         pp10S1;
	logic [35:0]         pp02S1;
	logic [35:0]         pp11S1;
	logic [35:0]         pp20S1;
	logic [35:0]         pp12S1;
	logic [35:0]         pp21S1;
	logic [35:0]         pp22S1;

	logic                sgnS2;
	logic [12:0]         expS2;
	logic                zeroS2;
	logic [63:0]         sumPS2;
	logic [63:0]         sumQS2;
	logic [63:0]         sumRS2;

	logic [63:0]         csaSum;
	logic [63:0]         csaCarry;

	logic                sgnS3;
	logic [12:0]         expS3;
	logic                zeroS3;
	logic [63:0]         sumS3;

	logic [53:0]         sigRnd;
	logic [12:0]         expNorm;
	logic [12:0]         expRnd;
	logic [dataW-1:0]    resultS4;

	logic [mulLatency-1:0] vldPipe;
	logic [regAddrW-1:0]   tagPipe [mulLatency];

	assign sgnA = inA[63];
	assign sgnB = inB[63];
	assign expA = inA[62:52];
	assign expB = inB[62:52];
	assign sigA = {1'b0, (expA != 11'd0), inA[51:0]};
	assign sigB = {1'b0, (expB != 11'd0), inB[51:0]};

	// Stage 1 forms 18-bit partial products. A0*B0 lies below the kept window.
	always_ff @(posedge clock)
	begin
		sgnS1  <= sgnA ^ sgnB;
		expS1  <= {2'b00, expA} + {2'b00, expB} - 13'(expBias);
		zeroS1 <= (expA == 11'd0) || (expB == 11'd0);	// Zero or subnormal.
		pp01S1 <= {18'h0, sigA[17:0]} * {18'h0, sigB[35:18]};
		pp10S1 <= {18'h0, sigA[35:18]} * {18'h0, sigB[17:0]};
		pp02S1 <= {18'h0, sigA[17:0]} * {18'h0, sigB[53:36]};
		pp11S1 <= {18'h0, sigA[35:18]} * {18'h0, sigB[35:18]};
		pp20S1 <= {18'h0, sigA[53:36]} * {18'h0, sigB[17:0]};
		pp12S1 <= {18'h0, sigA[35:18]} * {18'h0, sigB[53:36]};
		pp21S1 <= {18'h0, sigA[53:36]} * {18'h0, sigB[35:18]};
		pp22S1 <= {18'h0, sigA[53:36]} * {18'h0, sigB[53:36]};
	end

	// Stage 2 sums are aligned so bit 0 weighs 2^44.
	always_ff @(posedge clock)
	begin
		sgnS2  <= sgnS1;
		expS2  <= expS1;
		zeroS2 <= zeroS1;
		sumPS2 <= {pp22S1, pp11S1[35:8]};
		sumQS2 <= {18'h0, pp12S1, pp01S1[35:26]} + {18'h0, pp21S1, pp10S1[35:26]};
		sumRS2 <= {36'h0, pp02S1[35:8]} + {36'h0, pp20S1[35:8]};
	end

	assign csaSum   = sumPS2 ^ sumQS2 ^ sumRS2;
	assign csaCarry = {(sumPS2[62:0] & sumQS2[62:0]) |
		(sumPS2[62:0] & sumRS2[62:0]) |
		(sumQS2[62:0] & sumRS2[62:0]), 1'b0};

	// Stage 3 resolves the carry-save pair.
	always_ff @(posedge clock)
	begin
		sgnS3  <= sgnS2;
		expS3  <= expS2;
		zeroS3 <= zeroS2;
		sumS3  <= csaSum + csaCarry;
	end

	always_comb
	begin
		if (sumS3[61])
		begin
			sigRnd  = {1'b0, sumS3[61:9]} + {53'h0, sumS3[8]};	// Product at or above 2.
			expNorm = expS3 + 13'd1;
		end
		else
		begin
			sigRnd  = {1'b0, sumS3[60:8]} + {53'h0, sumS3[7]};
			expNorm = expS3;
		end
		expRnd = expNorm + {12'h0, sigRnd[53]};
		if (zeroS3)
			resultS4 = {sgnS3, 63'h0};
		else if (expRnd[12] || (expRnd == 13'd0))
			resultS4 = '0;	// Underflow flushes.
		else
			resultS4 = {sgnS3, expRnd[10:0], sigRnd[51:0]};
	end

	// Stage 4.
	always_ff @(posedge clock)
	begin
		outData <= resultS4;
	end

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
			vldPipe <= '0;
		else
			vldPipe <= {vldPipe[mulLatency-2:0], inValid};
	end

	always_ff @(posedge clock)
	begin
		tagPipe[0] <= inTag;
		for (int i = 1; i < mulLatency; i++)
			tagPipe[i] <= tagPipe[i-1];
	end

	assign outValid = vldPipe[mulLatency-1];
	assign outTag   = tagPipe[mulLatency-1];

endmodule

/* fpuIntConv.sv */
`timescale 1ns/1ps

module fpuIntConv import fpuPkg::*;
(
	input  logic                clock,
	input  logic                arstN,
	input  logic                inValid,
	input  logic [regAddrW-1:0] inTag,
	input  logic [dataW-1:0]    inA,
	output logic                outValid,
	output logic [regAddrW-1:0] outTag,
	output logic [dataW-1:0]    outData
);

	logic                   inNeg;
	logic [63:0]            inMag;
	logic [5:0]             leadPos;

	logic                   negS1;
	logic                   zeroS1;
	logic [63:0]            magS1;
	logic [5:0]             posS1;

	logic [63:0]            normMag;
	logic [53:0]            sigRnd;
	logic [10:0]            expOut;

	logic [convLatency-1:0] vldPipe;
	logic [regAddrW-1:0]    tagPipe [convLatency];

	assign inNeg = inA[63];
	assign inMag = inNeg ? (~inA + 64'd1) : inA;

	// Highest set bit wins.
	always_comb
	begin
		leadPos = '0;
		for (int i = 1; i < dataW; i++)
		begin
			if (inMag[i])
				leadPos = 6'(i);
		end
	end

	always_ff @(posedge clock)
	begin
		negS1  <= inNeg;
		zeroS1 <= (inMag == 64'd0);
		magS1  <= inMag;
		posS1  <= leadPos;
	end

	assign normMag = magS1 << (6'd63 - posS1);	// Leading one to bit 63.
	assign sigRnd  = {1'b0, normMag[63:11]} + {53'h0, normMag[10]};
	assign expOut  = 11'(expBias) + {5'h0, posS1} + {10'h0, sigRnd[53]};

	always_ff @(posedge clock)
	begin
		if (zeroS1)
			outData <= '0;
		else
			outData <= {negS1, expOut, sigRnd[51:0]};
	end

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
			vldPipe <= '0;
		else
			vldPipe <= {vldPipe[convLatency-2:0], inValid};
	end

	always_ff @(posedge clock)
	begin
		tagPipe[0] <= inTag;
		for (int i = 1; i < convLatency; i++)
			tagPipe[i] <= tagPipe[i-1];
	end

	assign outValid = vldPipe[convLatency-1];
	assign outTag   = tagPipe[convLatency-1];

endmodule

/* fpuWriteArbiter.sv */
`timescale 1ns/1ps

module fpuWriteArbiter import fpuPkg::*;
(
	input  logic                clock,
	input  logic                arstN,
	input  logic                mulDone,
	input  logic [regAddrW-1:0] mulTag,
	input  logic [dataW-1:0]    mulData,
	input  logic                convDone,
	input  logic [regAddrW-1:0] convTag,
	input  logic [dataW-1:0]    convData,
	input  logic                loadValid,
	input  logic [regAddrW-1:0] loadTag,
	input  logic [dataW-1:0]    loadData,
	output logic                wrEn,
	output logic [regAddrW-1:0] wrAddr,
	output logic [dataW-1:0]    wrData,
	output logic                wbValid,
	output logic [regAddrW-1:0] wbDst,
	output logic [dataW-1:0]    wbData
);

	// Index 0 is the converter, index 1 the loader. Lower index drains first.
	logic                 srcValid [2];
	logic [regAddrW-1:0]  srcTag [2];
	logic [dataW-1:0]     srcData [2];

	logic [queueCntW-1:0] qCount [2];
	logic [regAddrW-1:0]  qTag [2][queueDepth];
	logic [dataW-1:0]     qData [2][queueDepth];
	logic                 qPush [2];
	logic                 qPop [2];
	logic [queueIdxW-1:0] pushIdx [2];

	assign srcValid[0] = convDone;
	assign srcTag[0]   = convTag;
	assign srcData[0]  = convData;
	assign srcValid[1] = loadValid;
	assign srcTag[1]   = loadTag;
	assign srcData[1]  = loadData;

	always_comb
	begin
		logic portBusy;
		portBusy = mulDone;	// Multiplier always wins.
		wrAddr   = mulTag;
		wrData   = mulData;
		for (int q = 0; q < 2; q++)
		begin
			qPop[q]  = 1'b0;
			qPush[q] = srcValid[q];
			if (!portBusy && (qCount[q] != '0))
			begin
				qPop[q]  = 1'b1;
				wrAddr   = qTag[q][0];
				wrData   = qData[q][0];
				portBusy = 1'b1;
			end
			else if (!portBusy && srcValid[q])
			begin
				qPush[q] = 1'b0;	// Bypass.
				wrAddr   = srcTag[q];
				wrData   = srcData[q];
				portBusy = 1'b1;
			end
			pushIdx[q] = queueIdxW'(qCount[q]) - queueIdxW'(qPop[q]);
		end
		wrEn = portBusy;
	end

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			for (int q = 0; q < 2; q++)
				qCount[q] <= '0;
		end
		else
		begin
			for (int q = 0; q < 2; q++)
			begin
				if (qPush[q] && !qPop[q])
					qCount[q] <= qCount[q] + queueCntW'(1);
				else if (qPop[q] && !qPush[q])
					qCount[q] <= qCount[q] - queueCntW'(1);
			end
		end
	end

	// Shift toward the head on pop, then append at the tail.
	always_ff @(posedge clock)
	begin
		for (int q = 0; q < 2; q++)
		begin
			if (qPop[q])
			begin
				for (int i = 0; i < queueDepth - 1; i++)
				begin
					qTag[q][i]  <= qTag[q][i+1];
					qData[q][i] <= qData[q][i+1];
				end
			end
			if (qPush[q])
			begin
				qTag[q][pushIdx[q]]  <= srcTag[q];
				qData[q][pushIdx[q]] <= srcData[q];
			end
		end
	end

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
			wbValid <= 1'b0;
		else
			wbValid <= wrEn;
	end

	always_ff @(posedge clock)
	begin
		wbDst  <= wrAddr;
		wbData <= wrData;
	end

endmodule

/* fpuCluster.sv */
`timescale 1ns/1ps

module fpuCluster import fpuPkg::*;
(
	input  logic                clock,
	input  logic                arstN,
	input  logic                cmdValid,
	input  fpuOpE               cmdOp,
	input  logic [regAddrW-1:0] cmdDst,
	input  logic [regAddrW-1:0] cmdSrcA,
	input  logic [regAddrW-1:0] cmdSrcB,
	input  logic [dataW-1:0]    cmdImm,
	output logic                wbValid,
	output logic [regAddrW-1:0] wbDst,
	output logic [dataW-1:0]    wbData,
	input  logic [regAddrW-1:0] dbgAddr,
	output logic [dataW-1:0]    dbgData
);

	logic                mulValid;
	logic                convValid;
	logic                loadStrobe;

	logic                loadValid;
	logic [regAddrW-1:0] loadTag;
	logic [dataW-1:0]    loadData;

	logic [dataW-1:0]    rdDataA;
	logic [dataW-1:0]    rdDataB;

	logic                mulDone;
	logic [regAddrW-1:0] mulTag;
	logic [dataW-1:0]    mulData;
	logic                convDone;
	logic [regAddrW-1:0] convTag;
	logic [dataW-1:0]    convData;

	logic                wrEn;
	logic [regAddrW-1:0] wrAddr;
	logic [dataW-1:0]    wrData;

	assign mulValid   = cmdValid && (cmdOp == opMul);
	assign convValid  = cmdValid && (cmdOp == opConv);
	assign loadStrobe = cmdValid && (cmdOp == opLoad);

	// One-cycle loader stage.
	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
			loadValid <= 1'b0;
		else
			loadValid <= loadStrobe;
	end

	always_ff @(posedge clock)
	begin
		if (loadStrobe)
		begin
			loadTag  <= cmdDst;
			loadData <= cmdImm;
		end
	end

	fpuRegFile fpuRegFile_inst
	(
		.clock   (clock),
		.arstN   (arstN),
		.rdAddrA (cmdSrcA),
		.rdAddrB (cmdSrcB),
		.rdAddrC (dbgAddr),
		.rdDataA (rdDataA),
		.rdDataB (rdDataB),
		.rdDataC (dbgData),
		.wrEn    (wrEn),
		.wrAddr  (wrAddr),
		.wrData  (wrData)
	);

	fpuMul fpuMul_inst
	(
		.clock    (clock),
		.arstN    (arstN),
		.inValid  (mulValid),
		.inTag    (cmdDst),
		.inA      (rdDataA),
		.inB      (rdDataB),
		.outValid (mulDone),
		.outTag   (mulTag),
		.outData  (mulData)
	);

	fpuIntConv fpuIntConv_inst
	(
		.clock    (clock),
		.arstN    (arstN),
		.inValid  (convValid),
		.inTag    (cmdDst),
		.inA      (rdDataA),
		.outValid (convDone),
		.outTag   (convTag),
		.outData  (convData)
	);

	fpuWriteArbiter fpuWriteArbiter_inst
	(
		.clock     (clock),
		.arstN     (arstN),
		.mulDone   (mulDone),
		.mulTag    (mulTag),
		.mulData   (mulData),
		.convDone  (convDone),
		.convTag   (convTag),
		.convData  (convData),
		.loadValid (loadValid),
		.loadTag   (loadTag),
		.loadData  (loadData),
		.wrEn      (wrEn),
		.wrAddr    (wrAddr),
		.wrData    (wrData),
		.wbValid   (wbValid),
		.wbDst     (wbDst),
		.wbData    (wbData)
	);

endmodule

/* fpuClusterTb.sv */
`timescale 1ns/1ps

module fpuClusterTb import fpuPkg::*;
();

	localparam int clockPeriod    = 4;
	localparam int numMulCases    = 6;
	localparam int numEdgeCases   = 8;
	localparam int numConvCases   = 12;
	localparam int numBatches     = 4;
	localparam int batchLen       = 8;
	localparam int numCommands    = numRegs + 3 * (numMulCases + numEdgeCases)
		+ 2 * numConvCases + batchLen * (numBatches + 1);
	localparam int watchdogCycles = numCommands * 8 + 200;
	localparam int drainLimit     = 40;

	logic                clock = 1'b0;
	logic                arstN;
	logic                cmdValid;
	fpuOpE               cmdOp;
	logic [regAddrW-1:0] cmdDst;
	logic [regAddrW-1:0] cmdSrcA;
	logic [regAddrW-1:0] cmdSrcB;
	logic [dataW-1:0]    cmdImm;
	logic [dataW-1:0]    cmdExp;		// Expected write-back of the driven command.
	logic                wbValid;
	logic [regAddrW-1:0] wbDst;
	logic [dataW-1:0]    wbData;
	logic [regAddrW-1:0] dbgAddr;
	logic [dataW-1:0]    dbgData;

	logic                pending [numRegs];
	logic                pendIsMul [numRegs];
	logic [dataW-1:0]    pendData [numRegs];
	int                  pendCycle [numRegs];
	logic [dataW-1:0]    modelReg [numRegs];
	int                  pendingCount = 0;
	int                  cycle = 0;
	int                  checkErrors = 0;
	int                  stimErrors = 0;
	int                  testsPassed = 0;
	int                  testsFailed = 0;
	int                  lastErrors = 0;
	int                  testNum = 0;
	integer              seed;

	longint              poolInt [4];
	int                  poolExp [4];
	longint              convPool [4];

	fpuCluster fpuCluster_inst
	(
		.clock    (clock),
		.arstN    (arstN),
		.cmdValid (cmdValid),
		.cmdOp    (cmdOp),
		.cmdDst   (cmdDst),
		.cmdSrcA  (cmdSrcA),
		.cmdSrcB  (cmdSrcB),
		.cmdImm   (cmdImm),
		.wbValid  (wbValid),
		.wbDst    (wbDst),
		.wbData   (wbData),
		.dbgAddr  (dbgAddr),
		.dbgData  (dbgData)
	);

	always #(clockPeriod / 2) clock = ~clock;

	// Scoreboard, one outstanding write per destination.
	always @(posedge clock)
	begin
		if (!arstN)
		begin
			for (int i = 0; i < numRegs; i++)
			begin
				pending[i]  = 1'b0;
				modelReg[i] = '0;
			end
			pendingCount = 0;
		end
		else
		begin
			if (wbValid)
			begin
				assert (pending[wbDst])
				else
				begin
					$display("ERROR %0t wbDst r%0d written with no command pending", $time, wbDst);
					checkErrors++;
				end
				if (pending[wbDst])
				begin
					assert (wbData == pendData[wbDst])
					else
					begin
						$display("ERROR %0t wbData r%0d expected %h actual %h",
							$time, wbDst, pendData[wbDst], wbData);
						checkErrors++;
					end
					if (pendIsMul[wbDst])
					begin
						assert (cycle - pendCycle[wbDst] == mulLatency + 1)
						else
						begin
							$display("ERROR %0t wbValid multiply latency expected %0d actual %0d",
								$time, mulLatency + 1, cycle - pendCycle[wbDst]);
							checkErrors++;
						end
					end
					modelReg[wbDst] = pendData[wbDst];
					pending[wbDst]  = 1'b0;
					pendingCount--;
				end
			end
			if (cmdValid)
			begin
				pending[cmdDst]   = 1'b1;
				pendIsMul[cmdDst] = (cmdOp == opMul);
				pendData[cmdDst]  = cmdExp;
				pendCycle[cmdDst] = cycle;
				pendingCount++;
			end
			cycle++;
		end
	end

	// Exact for magnitudes below 2^53.
	function automatic logic [63:0] intToDouble(input longint v);
		logic [63:0] mag;
		int          e;
		logic        neg;
		if (v == 0)
			return 64'h0;
		neg = (v < 0);
		mag = neg ? 64'(-v) : 64'(v);
		e   = 52;
		while (!mag[52])
		begin
			mag = mag << 1;
			e--;
		end
		return {neg, 11'(1023 + e), mag[51:0]};
	endfunction

	function automatic logic [63:0] scaleDouble(input logic [63:0] d, input int k);
		return {d[63], 11'(int'(d[62:52]) + k), d[51:0]};
	endfunction

	function automatic logic [63:0] makeDouble(input longint v, input int k);
		return scaleDouble(intToDouble(v), k);
	endfunction

	function automatic logic [63:0] powerOfTwo(input int k);
		return {1'b0, 11'(1023 + k), 52'h0};
	endfunction

	function automatic logic [63:0] flipSign(input logic [63:0] d);
		return {~d[63], d[62:0]};
	endfunction

	function automatic longint randSmall();
		longint mag;
		mag = longint'($random(seed) & 32'h000f_ffff);
		if (mag == 0)
			mag = 1;
		if ($random(seed) & 1)
			return -mag;
		return mag;
	endfunction

	function automatic int randExp();
		return $random(seed) % 16;
	endfunction

	function automatic longint randConvInt();
		longint mag;
		mag = longint'({$random(seed), $random(seed)} & 64'h001f_ffff_ffff_ffff);
		if ($random(seed) & 1)
			return -mag;
		return mag;
	endfunction

	task automatic sendCmd(input fpuOpE op, input logic [regAddrW-1:0] dst,
		input logic [regAddrW-1:0] srcA, input logic [regAddrW-1:0] srcB,
		input logic [dataW-1:0] imm, input logic [dataW-1:0] expected);
		@(negedge clock);
		cmdValid = 1'b1;
		cmdOp    = op;
		cmdDst   = dst;
		cmdSrcA  = srcA;
		cmdSrcB  = srcB;
		cmdImm   = imm;
		cmdExp   = expected;
	endtask

	task automatic loadReg(input logic [regAddrW-1:0] dst, input logic [dataW-1:0] value);
		sendCmd(opLoad, dst, '0, '0, value, value);
	endtask

	task automatic waitDrain();
		int waited;
		waited = 0;
		@(negedge clock);
		cmdValid = 1'b0;
		while (pendingCount != 0 && waited < drainLimit)
		begin
			@(negedge clock);
			waited++;
		end
		if (pendingCount != 0)
		begin
			$display("%0d commands still had no write-back after %0d cycles", pendingCount, waited);
			stimErrors++;
		end
	endtask

	task automatic mulCase(input logic [63:0] a, input logic [63:0] b,
		input logic [63:0] expected, input logic [regAddrW-1:0] dst);
		loadReg(4'd1, a);
		loadReg(4'd2, b);
		waitDrain();
		sendCmd(opMul, dst, 4'd1, 4'd2, '0, expected);
		waitDrain();
	endtask

	task automatic convCase(input longint v, input logic [regAddrW-1:0] dst);
		loadReg(4'd1, 64'(v));
		waitDrain();
		sendCmd(opConv, dst, 4'd1, '0, '0, intToDouble(v));
		waitDrain();
	endtask

	task automatic finishTest(input string name);
		int errs;
		errs = checkErrors + stimErrors;
		testNum++;
		if (errs == lastErrors)
		begin
			testsPassed++;
			$display("test %0d %s: passed", testNum, name);
		end
		else
		begin
			testsFailed++;
			$display("test %0d %s: failed with %0d errors", testNum, name, errs - lastErrors);
		end
		lastErrors = errs;
	endtask

	initial
	begin
		#(watchdogCycles * clockPeriod);
		$display("run stopped by the watchdog after %0d cycles, the cluster hung", watchdogCycles);
		$display("TEST FAIL");
		$finish;
	end

	initial
	begin
		longint      a;
		longint      bv;
		int          ka;
		int          kb;
		int          sa;
		int          sb;
		logic [63:0] imm;
		seed     = 32'h9bb3_f60c;
		arstN    = 1'b0;
		cmdValid = 1'b0;
		cmdOp    = opLoad;
		cmdDst   = '0;
		cmdSrcA  = '0;
		cmdSrcB  = '0;
		cmdImm   = '0;
		cmdExp   = '0;
		dbgAddr  = '0;
		repeat (8) @(posedge clock);
		@(negedge clock);
		arstN = 1'b1;

		for (int i = 0; i < numRegs; i++)
		begin
			imm = {$random(seed), $random(seed)};
			loadReg(4'(i), imm);
		end
		waitDrain();
		for (int i = 0; i < numRegs; i++)
		begin
			@(negedge clock);
			dbgAddr = 4'(i);
			#1;
			assert (dbgData == modelReg[i])
			else
			begin
				$display("ERROR %0t dbgData r%0d expected %h actual %h",
					$time, i, modelReg[i], dbgData);
				stimErrors++;
			end
		end
		finishTest("load and read-back");

		for (int i = 0; i < numMulCases; i++)
		begin
			a  = randSmall();
			bv = randSmall();
			ka = randExp();
			kb = randExp();
			mulCase(makeDouble(a, ka), makeDouble(bv, kb), makeDouble(a * bv, ka + kb), 4'(3 + i));
		end
		finishTest("multiply latency and value");

		mulCase(64'h0, makeDouble(3, 0), 64'h0, 4'd5);
		mulCase(64'h8000_0000_0000_0000, makeDouble(3, 0), 64'h8000_0000_0000_0000, 4'd5);
		mulCase(64'h0000_0000_0000_0001, makeDouble(-5, 0), 64'h8000_0000_0000_0000, 4'd5);
		mulCase(powerOfTwo(-600), flipSign(powerOfTwo(-600)), 64'h0, 4'd5);
		mulCase(powerOfTwo(-512), powerOfTwo(-511), 64'h0, 4'd5);		// Biased exponent hits 0.
		mulCase(powerOfTwo(-511), powerOfTwo(-511), powerOfTwo(-1022), 4'd5);
		mulCase(makeDouble(3, -1), makeDouble(3, -1), makeDouble(9, -2), 4'd5);
		mulCase(makeDouble(3, -1), makeDouble(-7, -2), makeDouble(-21, -3), 4'd5);
		finishTest("multiply edge cases");

		convCase(0, 4'd6);
		convCase(-longint'(64'h001f_ffff_ffff_ffff), 4'd7);
		convCase(longint'(64'h001f_ffff_ffff_ffff), 4'd8);
		for (int i = 0; i < numConvCases - 3; i++)
			convCase(randConvInt(), 4'(9 + i % 6));
		finishTest("conversion");

		// Doubles in r0 to r3, integers in r4 to r7.
		for (int i = 0; i < 4; i++)
		begin
			poolInt[i]  = randSmall();
			poolExp[i]  = randExp();
			convPool[i] = randConvInt();
			loadReg(4'(i), makeDouble(poolInt[i], poolExp[i]));
			loadReg(4'(4 + i), 64'(convPool[i]));
		end
		waitDrain();
		for (int b = 0; b < numBatches; b++)
		begin
			for (int i = 0; i < batchLen; i++)
			begin
				sa = $unsigned($random(seed)) % 4;
				sb = $unsigned($random(seed)) % 4;
				case ((i + b) % 3)
					0: sendCmd(opMul, 4'(8 + i), 4'(sa), 4'(sb), '0,
						makeDouble(poolInt[sa] * poolInt[sb], poolExp[sa] + poolExp[sb]));
					1: sendCmd(opConv, 4'(8 + i), 4'(4 + sa), '0, '0, intToDouble(convPool[sa]));
					default:
					begin
						imm = {$random(seed), $random(seed)};
						sendCmd(opLoad, 4'(8 + i), '0, '0, imm, imm);
					end
				endcase
			end
			waitDrain();
		end
		finishTest("contention");

		$display("tests passed: %0d, tests failed: %0d, errors: %0d",
			testsPassed, testsFailed, checkErrors + stimErrors);
		if (testsFailed == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

/* fpuCluster.f */
fpuPkg.sv
fpuRegFile.sv
fpuMul.sv
fpuIntConv.sv
fpuWriteArbiter.sv
fpuCluster.sv
fpuClusterTb.sv

/* runSim.sh */
#!/usr/bin/env bash
# Compiles the cluster and its testbench with Verilator, runs it and checks the log.
set -u
cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --assert -f fpuCluster.f --top-module fpuClusterTb \
	--Mdir obj_dir -o simFpuCluster
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/simFpuCluster > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

if grep -q "TEST FAIL" "$logFile"; then
	exit 1
fi
exit 0
